// File: design/fanin_cfg_pkg.sv
`default_nettype none

package fanin_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // stream sizes
  ////////////////////////////////////////////////////////////////////////////

  // number of merged input streams
  localparam int NUM_FANIN = 4;

  // payload width of one beat
  localparam int DATA_WIDTH = 32;

  // bits needed to name one input channel
  localparam int CHAN_W = 2;

  ////////////////////////////////////////////////////////////////////////////
  // shared types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [CHAN_W-1:0] chan_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

endpackage

`default_nettype wire

// File: design/fanin_arb_pkg.sv
`default_nettype none

package fanin_arb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // arbiter states
  ////////////////////////////////////////////////////////////////////////////

  // ARB_RELEASE is the one-cycle gap after a packet end
  typedef enum logic [1:0] {
    ARB_IDLE    = 2'd0,
    ARB_GRANT   = 2'd1,
    ARB_RELEASE = 2'd2
  } arb_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // packet length limit
  ////////////////////////////////////////////////////////////////////////////

  // longer source packets get cut here
  localparam int MAX_BEATS = 16;

  // wide enough for MAX_BEATS - 1
  localparam int BEAT_CNT_W = 5;

endpackage

`default_nettype wire

// File: design/fanin_prio_encoder.sv
`timescale 1ns/1ps
`default_nettype none

// highest channel index wins
module fanin_prio_encoder (
  input  wire logic [fanin_cfg_pkg::NUM_FANIN-1:0] tvalid,
  output fanin_cfg_pkg::chan_t                     prio_chan,
  output logic                                     prio_any
);

  // scan from the top index down and keep the first valid channel
  always_comb begin
    prio_chan = '0;
    prio_any  = 1'b0;
    for (int i = fanin_cfg_pkg::NUM_FANIN - 1; i >= 0; i--) begin
      if (!prio_any && tvalid[i]) begin
        prio_chan = fanin_cfg_pkg::chan_t'(i);
        prio_any  = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/fanin_arb_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module fanin_arb_fsm (
  input  wire logic           m_axis_clk,
  input  wire logic           m_axis_rst,

  // request side
  input  fanin_cfg_pkg::chan_t prio_chan,
  input  wire logic           prio_any,

  // beat accept and packet end info
  input  wire logic           take,
  input  wire logic           beat_last,
  input  wire logic           at_limit,

  // grant
  output fanin_cfg_pkg::chan_t grant_chan,
  output logic                grant_active
);

  fanin_arb_pkg::arb_state_t state;
  fanin_arb_pkg::arb_state_t state_next;

  logic pkt_end;

  // a packet ends on the source tlast or on the forced cut
  assign pkt_end = take && (beat_last || at_limit);

  //////////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      fanin_arb_pkg::ARB_IDLE: begin
        if (prio_any) begin
          state_next = fanin_arb_pkg::ARB_GRANT;
        end
      end
      fanin_arb_pkg::ARB_GRANT: begin
        if (pkt_end) begin
          state_next = fanin_arb_pkg::ARB_RELEASE;
        end
      end
      fanin_arb_pkg::ARB_RELEASE: begin
        state_next = fanin_arb_pkg::ARB_IDLE;
      end
      default: begin
        state_next = fanin_arb_pkg::ARB_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // state and grant registers
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk) begin
    if (m_axis_rst) begin
      state      <= fanin_arb_pkg::ARB_IDLE;
      grant_chan <= '0;
    end else begin
      state <= state_next;
      // winner is frozen for the whole packet
      if (state == fanin_arb_pkg::ARB_IDLE && prio_any) begin
        grant_chan <= prio_chan;
      end
    end
  end

  assign grant_active = (state == fanin_arb_pkg::ARB_GRANT);

  // grant must not move mid-packet
  grant_stable_a: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    (state == fanin_arb_pkg::ARB_GRANT) |=> $stable(grant_chan)
  );

  // output stage only accepts beats while a grant is held
  take_in_grant_a: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    take |-> (state == fanin_arb_pkg::ARB_GRANT)
  );

endmodule

`default_nettype wire

// File: design/fanin_beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

module fanin_beat_counter (
  input  wire logic m_axis_clk,
  input  wire logic m_axis_rst,

  // accept strobe and source tlast of the granted channel
  input  wire logic take,
  input  wire logic beat_last,

  // high on the take of the MAX_BEATS-th beat
  output logic      at_limit
);

  logic [fanin_arb_pkg::BEAT_CNT_W-1:0] beat_cnt;

  // count holds the number of beats already taken in this packet
  assign at_limit = take && (int'(beat_cnt) == fanin_arb_pkg::MAX_BEATS - 1);

  always_ff @(posedge m_axis_clk) begin
    if (m_axis_rst) begin
      beat_cnt <= '0;
    end else if (take) begin
      if (beat_last || at_limit) begin
        // next beat starts a fresh packet
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // cut must fire before the count can run past the limit
  cnt_bound_a: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    int'(beat_cnt) <= fanin_arb_pkg::MAX_BEATS - 1
  );

endmodule

`default_nettype wire

// File: design/fanin_out_reg.sv
`timescale 1ns/1ps
`default_nettype none

module fanin_out_reg (
  input  wire logic m_axis_clk,
  input  wire logic m_axis_rst,

  // grant from the FSM
  input  fanin_cfg_pkg::chan_t grant_chan,
  input  wire logic            grant_active,

  // all input streams
  input  wire logic [fanin_cfg_pkg::NUM_FANIN-1:0]                          s_axis_tvalid,
  input  wire logic [fanin_cfg_pkg::NUM_FANIN*fanin_cfg_pkg::DATA_WIDTH-1:0] s_axis_tdata,
  input  wire logic [fanin_cfg_pkg::NUM_FANIN-1:0]                          s_axis_tlast,

  // forced cut from the beat counter
  input  wire logic at_limit,

  output logic take,

  // master side
  output logic                 m_axis_tvalid,
  input  wire logic            m_axis_tready,
  output fanin_cfg_pkg::data_t m_axis_tdata,
  output logic                 m_axis_tlast,
  output fanin_cfg_pkg::chan_t m_axis_tuser
);

  fanin_cfg_pkg::data_t sel_data;
  logic                 sel_valid;
  logic                 sel_last;
  logic                 out_free;

  //////////////////////////////////////////////////////////////////////////
  // granted channel select
  //////////////////////////////////////////////////////////////////////////

  assign sel_data  = s_axis_tdata[grant_chan * fanin_cfg_pkg::DATA_WIDTH +: fanin_cfg_pkg::DATA_WIDTH];
  assign sel_valid = s_axis_tvalid[grant_chan];
  assign sel_last  = s_axis_tlast[grant_chan];

  // register empty or being drained this cycle
  assign out_free = !m_axis_tvalid || m_axis_tready;
  assign take     = grant_active && sel_valid && out_free;

  //////////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk) begin
    if (m_axis_rst) begin
      m_axis_tvalid <= 1'b0;
    end else if (take) begin
      m_axis_tvalid <= 1'b1;
    end else if (m_axis_tready) begin
      m_axis_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge m_axis_clk) begin
    if (take) begin
      m_axis_tdata <= sel_data;
      m_axis_tlast <= sel_last || at_limit;
      m_axis_tuser <= grant_chan;
    end
  end

  // held beat must not change under back-pressure
  hold_stable_a: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    (m_axis_tvalid && !m_axis_tready) |=>
      (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)
       && $stable(m_axis_tuser))
  );

endmodule

`default_nettype wire

// File: design/axis_fan_in.sv
`timescale 1ns/1ps
`default_nettype none

// four AXI-stream inputs merged onto one output, tuser carries the source
module axis_fan_in (
  input  wire logic m_axis_clk,
  input  wire logic m_axis_rst,

  // slave side, channel n at slice n
  input  wire logic [fanin_cfg_pkg::NUM_FANIN-1:0]                          s_axis_tvalid,
  output logic      [fanin_cfg_pkg::NUM_FANIN-1:0]                          s_axis_tready,
  input  wire logic [fanin_cfg_pkg::NUM_FANIN*fanin_cfg_pkg::DATA_WIDTH-1:0] s_axis_tdata,
  input  wire logic [fanin_cfg_pkg::NUM_FANIN-1:0]                          s_axis_tlast,

  // master side
  output logic                 m_axis_tvalid,
  input  wire logic            m_axis_tready,
  output fanin_cfg_pkg::data_t m_axis_tdata,
  output logic                 m_axis_tlast,
  output fanin_cfg_pkg::chan_t m_axis_tuser
);

  fanin_cfg_pkg::chan_t prio_chan;
  logic                 prio_any;
  fanin_cfg_pkg::chan_t grant_chan;
  logic                 grant_active;
  logic                 take;
  logic                 beat_last;
  logic                 at_limit;

  //////////////////////////////////////////////////////////////////////////
  // request and grant
  //////////////////////////////////////////////////////////////////////////

  fanin_prio_encoder prio_i (
    .tvalid    (s_axis_tvalid),
    .prio_chan (prio_chan),
    .prio_any  (prio_any)
  );

  fanin_arb_fsm arb_i (
    .m_axis_clk   (m_axis_clk),
    .m_axis_rst   (m_axis_rst),
    .prio_chan    (prio_chan),
    .prio_any     (prio_any),
    .take         (take),
    .beat_last    (beat_last),
    .at_limit     (at_limit),
    .grant_chan   (grant_chan),
    .grant_active (grant_active)
  );

  // source tlast of whichever channel holds the grant
  assign beat_last = s_axis_tlast[grant_chan];

  fanin_beat_counter cnt_i (
    .m_axis_clk (m_axis_clk),
    .m_axis_rst (m_axis_rst),
    .take       (take),
    .beat_last  (beat_last),
    .at_limit   (at_limit)
  );

  //////////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////////

  fanin_out_reg out_i (
    .m_axis_clk    (m_axis_clk),
    .m_axis_rst    (m_axis_rst),
    .grant_chan    (grant_chan),
    .grant_active  (grant_active),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tlast  (s_axis_tlast),
    .at_limit      (at_limit),
    .take          (take),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tuser  (m_axis_tuser)
  );

  // one-hot ready, only the granted channel sees the accept
  for (genvar n = 0; n < fanin_cfg_pkg::NUM_FANIN; n++) begin : g_ready
    assign s_axis_tready[n] = take && (grant_chan == fanin_cfg_pkg::chan_t'(n));
  end

  tready_onehot_a: assert property (
    @(posedge m_axis_clk) disable iff (m_axis_rst)
    $onehot0(s_axis_tready)
  );

endmodule

`default_nettype wire

// File: verification/axis_fan_in_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axis_fan_in_tb;

  localparam int NUM_FANIN    = fanin_cfg_pkg::NUM_FANIN;
  localparam int DW           = fanin_cfg_pkg::DATA_WIDTH;
  localparam int RESET_CYCLES = 5;
  // one short packet per channel for the priority check before random traffic
  localparam int PRIO_LEN     = 4;
  localparam int RAND_BEATS   = 250;
  localparam int TOTAL_BEATS  = NUM_FANIN * (PRIO_LEN + RAND_BEATS);

  logic                     m_axis_clk = 1'b0;
  logic                     m_axis_rst = 1'b1;
  logic [NUM_FANIN-1:0]     s_axis_tvalid = '0;
  logic [NUM_FANIN-1:0]     s_axis_tready;
  logic [NUM_FANIN*DW-1:0]  s_axis_tdata = '0;
  logic [NUM_FANIN-1:0]     s_axis_tlast = '0;
  logic                     m_axis_tvalid;
  logic                     m_axis_tready = 1'b1;
  fanin_cfg_pkg::data_t     m_axis_tdata;
  logic                     m_axis_tlast;
  fanin_cfg_pkg::chan_t     m_axis_tuser;

  axis_fan_in dut_i (
    .m_axis_clk    (m_axis_clk),
    .m_axis_rst    (m_axis_rst),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tlast  (s_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tuser  (m_axis_tuser)
  );

  initial begin
    forever #5 m_axis_clk = ~m_axis_clk;
  end

  logic [31:0]    lfsr = 32'hbaad_4b50;
  logic           random_on = 1'b0;
  bit [NUM_FANIN-1:0] rand_started = '0;
  int             budget   [NUM_FANIN] = '{default: PRIO_LEN};
  int             pkt_left [NUM_FANIN] = '{default: 0};
  int             gap_left [NUM_FANIN] = '{default: 0};

  // sent beats as {tlast, data} and beat count since each channel's last packet end
  logic [DW:0]    sent_q   [NUM_FANIN][$];
  int             run_cnt  [NUM_FANIN] = '{default: 0};
  int             checked_beats = 0;
  int             pkt_starts = 0;
  logic           in_pkt = 1'b0;
  fanin_cfg_pkg::chan_t pkt_chan = '0;

  // copy of a beat stalled by back-pressure
  logic                 hold_valid = 1'b0;
  fanin_cfg_pkg::data_t hold_data = '0;
  logic                 hold_last = 1'b0;
  fanin_cfg_pkg::chan_t hold_chan = '0;

  ////////////////////////////////////////////////////////////////////////////
  // random source and error reporting
  ////////////////////////////////////////////////////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("FAIL %0t: %s", $time, msg));
  endtask

  task automatic check_data(input fanin_cfg_pkg::data_t got, input fanin_cfg_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: tdata %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_chan(input fanin_cfg_pkg::chan_t got, input fanin_cfg_pkg::chan_t exp,
                            input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: channel %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: tlast %b, expected %b", what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: %b, expected %b", what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // source generators
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_beat(input int n);
    s_axis_tvalid[n]          <= 1'b1;
    s_axis_tdata[n*DW +: DW]  <= rand_bits(DW);
    s_axis_tlast[n]           <= (pkt_left[n] == 1);
  endtask

  always @(posedge m_axis_clk) begin
    int len;
    len = 0;
    m_axis_tready <= random_on ? (rand_bits(2) != 0) : 1'b1;
    for (int n = 0; n < NUM_FANIN; n++) begin
      if (random_on && !rand_started[n]) begin
        budget[n] += RAND_BEATS;
        rand_started[n] = 1'b1;
      end
      if (s_axis_tvalid[n] && s_axis_tready[n]) begin
        sent_q[n].push_back({s_axis_tlast[n], s_axis_tdata[n*DW +: DW]});
        pkt_left[n]--;
        budget[n]--;
        if (pkt_left[n] > 0) begin
          load_beat(n);
        end else begin
          s_axis_tvalid[n] <= 1'b0;
          gap_left[n] = int'(rand_bits(3));
        end
      end else if (!s_axis_tvalid[n]) begin
        if (gap_left[n] > 0) begin
          gap_left[n]--;
        end else if (budget[n] > 0) begin
          len = random_on ? 1 + int'(rand_bits(5) % 24) : PRIO_LEN;
          if (len > budget[n]) begin
            len = budget[n];
          end
          pkt_left[n] = len;
          load_beat(n);
        end
      end
    end
  end

  // every source has sent its whole budget and the output register is empty
  function automatic bit traffic_done();
    bit done;
    done = (rand_started == '1) && (s_axis_tvalid == '0) && !m_axis_tvalid;
    for (int n = 0; n < NUM_FANIN; n++) begin
      if (budget[n] != 0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // output monitor and model
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_beat();
    int          ch;
    logic [DW:0] exp_beat;
    logic        exp_last;
    ch = int'(m_axis_tuser);
    if (sent_q[ch].size() == 0) begin
      abort_run($sformatf("output beat at %0t names channel %0d, which has no beat pending",
                          $time, ch));
    end else begin
      exp_beat = sent_q[ch].pop_front();
      // forced cut on the MAX_BEATS-th beat
      exp_last = exp_beat[DW] || (run_cnt[ch] == fanin_arb_pkg::MAX_BEATS - 1);
      if (in_pkt) begin
        check_chan(m_axis_tuser, pkt_chan, "packet interleaved");
      end else begin
        if (pkt_starts < NUM_FANIN) begin
          check_chan(m_axis_tuser, fanin_cfg_pkg::chan_t'(NUM_FANIN - 1 - pkt_starts),
                     "priority order");
        end
        pkt_starts++;
        pkt_chan = m_axis_tuser;
      end
      check_data(m_axis_tdata, exp_beat[DW-1:0], "beat data");
      check_last(m_axis_tlast, exp_last, "beat end");
      run_cnt[ch] = exp_last ? 0 : run_cnt[ch] + 1;
      in_pkt = !m_axis_tlast;
      checked_beats++;
    end
  endtask

  always @(posedge m_axis_clk) begin
    if (!m_axis_rst) begin
      if (hold_valid) begin
        check_flag(m_axis_tvalid, 1'b1, "tvalid under back-pressure");
        check_data(m_axis_tdata, hold_data, "held beat");
        check_last(m_axis_tlast, hold_last, "held beat");
        check_chan(m_axis_tuser, hold_chan, "held beat");
      end
      hold_valid = m_axis_tvalid && !m_axis_tready;
      hold_data  = m_axis_tdata;
      hold_last  = m_axis_tlast;
      hold_chan  = m_axis_tuser;
      if (m_axis_tvalid && m_axis_tready) begin
        check_beat();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int leftover;
    leftover = 0;
    repeat (RESET_CYCLES) @(posedge m_axis_clk);
    m_axis_rst <= 1'b0;
    @(negedge m_axis_clk);
    check_flag(m_axis_tvalid, 1'b0, "m_axis_tvalid after reset");
    for (int n = 0; n < NUM_FANIN; n++) begin
      check_flag(s_axis_tready[n], 1'b0, $sformatf("s_axis_tready[%0d] after reset", n));
    end
    // random traffic starts once the priority packets are out
    while (checked_beats < NUM_FANIN * PRIO_LEN) @(negedge m_axis_clk);
    @(posedge m_axis_clk);
    random_on <= 1'b1;
    while (!traffic_done()) @(negedge m_axis_clk);
    for (int n = 0; n < NUM_FANIN; n++) begin
      leftover += sent_q[n].size();
    end
    if (leftover == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      abort_run($sformatf("%0d beats went into the DUT and never came out", leftover));
    end
  end

  initial begin
    fanin_arb_pkg::arb_state_t st;
    repeat (TOTAL_BEATS * 40) @(posedge m_axis_clk);
    st = dut_i.arb_i.state;
    abort_run($sformatf("timeout: only %0d of %0d beats came out, arbiter in %s",
                        checked_beats, TOTAL_BEATS, st.name()));
  end

endmodule

`default_nettype wire

// File: filelist.f
design/fanin_cfg_pkg.sv
design/fanin_arb_pkg.sv
design/fanin_prio_encoder.sv
design/fanin_arb_fsm.sv
design/fanin_beat_counter.sv
design/fanin_out_reg.sv
design/axis_fan_in.sv
verification/axis_fan_in_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the AXI-stream fan-in testbench with Verilator.
# Any failing check ends the simulation with $fatal, which gives a
# non-zero exit status and stops this script.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module axis_fan_in_tb \
  -f filelist.f \
  -o axis_fan_in_sim

./obj_dir/axis_fan_in_sim
